/* syrf_golden.txt */
# columns: op, address or channel, value, all hex. W bus write, R bus read with expected byte,
# S adc model value for a channel, T wait cycles, I expected irq_n, P expected ast pulse count
R 010000 00  # REG_CTRL after reset
R 010004 00  # REG_STATUS
R 010012 00  # REG_SAMPLE_LO ch0
R 010025 00  # REG_SMOOTH_HI ch1
I 0 1
W 010010 FF  # REG_THR_LO ch0, keeps ch0 below threshold
W 010011 FF  # REG_THR_HI ch0
S 0 1234
S 1 4321
W 010000 01  # REG_CTRL, ch1 stays disabled
W 010001 03  # REG_START both
R 010004 10  # ch0 busy
W 010001 01  # REG_START while busy, ignored
T 0 46
R 010012 34  # REG_SAMPLE_LO ch0
R 010013 12  # REG_SAMPLE_HI ch0
R 010014 34  # REG_SMOOTH_LO ch0, shift 0 copies
R 010015 12  # REG_SMOOTH_HI ch0
R 010022 00  # REG_SAMPLE_LO ch1 untouched
R 010023 00  # REG_SAMPLE_HI ch1
R 010004 00  # idle, no alarm
W 020000 03  # foreign device id
W 020010 55
R 010000 01  # REG_CTRL unchanged
R 010010 FF  # REG_THR_LO ch0 unchanged
R 020000 00  # foreign read
W 010002 02  # REG_SMOOTH shift 2
R 010002 02
S 0 2234
W 010001 01
T 0 46
R 010013 22  # REG_SAMPLE_HI ch0
R 010014 34  # 1234 + (1000 >>> 2) = 1634
R 010015 16
S 0 0001
W 010001 01
T 0 46
R 010012 01  # REG_SAMPLE_LO ch0
R 010014 A7  # 1634 + floor(-1633 / 4) = 10A7
R 010015 10
W 010020 00  # REG_THR_LO ch1
W 010021 80  # REG_THR_HI ch1, threshold 8000
W 010003 02  # REG_IRQ_MASK ch1
W 010000 03  # REG_CTRL both
S 1 8000
W 010001 02
T 0 46
R 010004 00  # equal to threshold, no alarm
I 0 1
P 1 0
S 1 8001
W 010001 02
T 0 46
R 010004 02  # sticky alarm ch1
I 0 0
T 0 30
P 1 1
W 010004 02  # clear ch1 alarm
R 010004 00
I 0 1
W 010003 00  # mask off
S 1 9000
W 010001 02
T 0 46
R 010004 02
I 0 1
T 0 30
P 1 2
P 0 0
R 010023 90  # REG_SAMPLE_HI ch1
R 010024 00  # smoothed ch1 0 -> 2000 -> 3800 -> 4E00
R 010025 4E

/* compile.f */
syrf_bus_pkg.sv
syrf_adc_pkg.sv
adc_serial_rx.sv
smooth_filter.sv
alarm_hold.sv
syrf_regs.sv
syrf_top.sv
tb_syrf_checker.sv
tb_syrf_top.sv

/* run_sim.sh */
#!/bin/sh
# build the syrf testbench with verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_syrf_top -o tb_syrf_top \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_syrf_top > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1 || exit 0

/* tb_syrf_top.sv */
// testbench top for the syrf data-acquisition core
// golden-file commands, adc slave models and a watchdog around the DUT

`timescale 1ns/1ps

module tb_syrf_top import syrf_bus_pkg::*, syrf_adc_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int CYC_PER_CMD  = 200;
  localparam int WD_MARGIN    = 1000;

  logic                 clk_sys;
  logic                 reset;
  fx_req_t              fx_req;
  logic [FX_DATA_W-1:0] fx_q;
  logic [NUM_CH-1:0]    cs_n;
  logic [NUM_CH-1:0]    sclk;
  logic [NUM_CH-1:0]    sdata;
  logic [NUM_CH-1:0]    ast_ctrl;
  logic                 irq_n;
  logic [7:0]           chk_op;
  logic [7:0]           chk_ch;
  logic [SAMPLE_W-1:0]  chk_val;
  logic                 done;
  int                   err_count;
  int                   seed = 80;
  logic                 bad_cmd;
  logic                 loaded;
  int                   n_cmds;
  logic [7:0]           op_q [$];
  logic [23:0]          addr_q [$];
  logic [15:0]          val_q [$];
  logic [SAMPLE_W-1:0]  model_val [NUM_CH];
  logic [SAMPLE_W-1:0]  model_sh [NUM_CH];
  logic [NUM_CH-1:0]    cs_q;
  logic [NUM_CH-1:0]    sclk_q;

  syrf_top DUT (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .fx_req   (fx_req),
    .fx_q     (fx_q),
    .cs_n     (cs_n),
    .sclk     (sclk),
    .sdata    (sdata),
    .ast_ctrl (ast_ctrl),
    .irq_n    (irq_n)
  );

  tb_syrf_checker u_checker (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .fx_q      (fx_q),
    .cs_n      (cs_n),
    .sclk      (sclk),
    .ast_ctrl  (ast_ctrl),
    .irq_n     (irq_n),
    .chk_op    (chk_op),
    .chk_ch    (chk_ch),
    .chk_val   (chk_val),
    .done      (done),
    .err_count (err_count)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
  end

  // ----------------------------------------------------------------------
  // adc slave models load at cs_n fall and shift out on each sclk fall
  // ----------------------------------------------------------------------
  always @(negedge clk_sys) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (cs_q[i] && !cs_n[i]) model_sh[i] = model_val[i];
      if (!cs_n[i] && sclk_q[i] && !sclk[i]) begin
        sdata[i]    = model_sh[i][SAMPLE_W-1];
        model_sh[i] = {model_sh[i][SAMPLE_W-2:0], 1'b0};
      end
    end
    cs_q   = cs_n;
    sclk_q = sclk;
  end

  // bus idle with random address and data
  task automatic drive_idle();
    fx_req.wr    = 1'b0;
    fx_req.rd    = 1'b0;
    fx_req.waddr = FX_ADDR_W'($random(seed));
    fx_req.raddr = FX_ADDR_W'($random(seed));
    fx_req.data  = FX_DATA_W'($random(seed));
    chk_op       = 8'h00;
  endtask

  // one golden command entered and left on a falling edge
  task automatic run_cmd(input logic [7:0] op, input logic [23:0] a, input logic [15:0] v);
    chk_ch  = a[7:0];
    chk_val = v;
    case (op)
      "W": begin
        fx_req.wr    = 1'b1;
        fx_req.waddr = a[FX_ADDR_W-1:0];
        fx_req.data  = v[FX_DATA_W-1:0];
      end
      "R": begin
        fx_req.rd    = 1'b1;
        fx_req.raddr = a[FX_ADDR_W-1:0];
        chk_op       = "R";
      end
      "S": begin
        for (int i = 0; i < NUM_CH; i++) begin
          if (int'(a) == i) model_val[i] = v;
        end
      end
      "I": chk_op = "I";
      "P": chk_op = "P";
      "T": repeat (int'(v) - 1) @(negedge clk_sys);
      default: begin
        bad_cmd = 1'b1;
        $display("unknown golden command '%c'", op);
      end
    endcase
    @(negedge clk_sys);
    drive_idle();
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int          fd;
    int          n;
    string       line;
    logic [23:0] a;
    logic [15:0] v;
    reset   = 1'b1;
    done    = 1'b0;
    bad_cmd = 1'b0;
    loaded  = 1'b0;
    n_cmds  = 0;
    sdata   = '0;
    cs_q    = '1;
    sclk_q  = '1;
    for (int i = 0; i < NUM_CH; i++) begin
      model_val[i] = '0;
      model_sh[i]  = '0;
    end
    drive_idle();
    fd = $fopen("syrf_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open syrf_golden.txt");
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      line = "";
      while ($fgets(line, fd) != 0) begin
        if (line.len() >= 3 && line.getc(0) != "#") begin
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, v);
          if (n == 2) begin
            op_q.push_back(line.getc(0));
            addr_q.push_back(a);
            val_q.push_back(v);
          end else begin
            bad_cmd = 1'b1;
            $display("malformed golden line: %s", line);
          end
        end
        line = "";
      end
      $fclose(fd);
      n_cmds = op_q.size();
      loaded = 1'b1;

      repeat (RESET_CYCLES) @(negedge clk_sys);
      reset = 1'b0;
      foreach (op_q[i]) run_cmd(op_q[i], addr_q[i], val_q[i]);

      done = 1'b1;
      repeat (2) @(posedge clk_sys);
      if (err_count == 0 && !bad_cmd) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

  // watchdog sized from the number of golden commands
  initial begin
    wait (loaded);
    repeat (n_cmds * CYC_PER_CMD + WD_MARGIN) @(posedge clk_sys);
    $display("timeout: golden commands did not finish in %0d cycles",
             n_cmds * CYC_PER_CMD + WD_MARGIN);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* tb_syrf_checker.sv */
// testbench checker for the syrf core
// compares read data, irq_n and ast pulses with the golden expectations

`timescale 1ns/1ps

module tb_syrf_checker import syrf_bus_pkg::*, syrf_adc_pkg::*; (
  input  logic                 clk_sys,
  input  logic                 reset,
  input  logic [FX_DATA_W-1:0] fx_q,
  input  logic [NUM_CH-1:0]    cs_n,
  input  logic [NUM_CH-1:0]    sclk,
  input  logic [NUM_CH-1:0]    ast_ctrl,
  input  logic                 irq_n,
  input  logic [7:0]           chk_op,
  input  logic [7:0]           chk_ch,
  input  logic [SAMPLE_W-1:0]  chk_val,
  input  logic                 done,
  output int                   err_count
);

  int                   checks;
  int                   width [NUM_CH];
  int                   pulses [NUM_CH];
  int                   seen;
  logic                 rd_pend;
  logic [FX_DATA_W-1:0] rd_exp;
  logic                 after_reset;
  logic                 reported;

  always @(posedge clk_sys) begin
    if (reset) begin
      checks      = 0;
      err_count   = 0;
      rd_pend     = 1'b0;
      after_reset = 1'b1;
      reported    = 1'b0;
      for (int i = 0; i < NUM_CH; i++) begin
        width[i]  = 0;
        pulses[i] = 0;
      end
    end else begin
      // idle levels on the first cycle out of reset
      if (after_reset) begin
        checks++;
        if (cs_n !== '1 || sclk !== '1 || irq_n !== 1'b1 || ast_ctrl !== '0 || fx_q !== '0) begin
          err_count++;
          $display("[FAIL] %0t: after reset cs_n=%b sclk=%b irq_n=%b ast=%b fx_q=%h",
                   $time, cs_n, sclk, irq_n, ast_ctrl, fx_q);
        end
      end
      after_reset = 1'b0;

      // ast pulse widths
      for (int i = 0; i < NUM_CH; i++) begin
        if (ast_ctrl[i]) begin
          width[i]++;
        end else if (width[i] != 0) begin
          checks++;
          pulses[i]++;
          if (width[i] != AST_HOLD) begin
            err_count++;
            $display("[FAIL] %0t: ast[%0d] high for %0d cycles, expected %0d",
                     $time, i, width[i], AST_HOLD);
          end
          width[i] = 0;
        end
      end

      // read data is valid one cycle after the strobe
      if (rd_pend) begin
        checks++;
        if (fx_q !== rd_exp) begin
          err_count++;
          $display("[FAIL] %0t: read data %h, expected %h", $time, fx_q, rd_exp);
        end
      end
      rd_pend = 1'b0;

      case (chk_op)
        "R": begin
          rd_pend = 1'b1;
          rd_exp  = chk_val[FX_DATA_W-1:0];
        end
        "I": begin
          checks++;
          if (irq_n !== chk_val[0]) begin
            err_count++;
            $display("[FAIL] %0t: irq_n is %b, expected %b", $time, irq_n, chk_val[0]);
          end
        end
        "P": begin
          checks++;
          seen = -1;
          for (int i = 0; i < NUM_CH; i++) begin
            if (int'(chk_ch) == i) seen = pulses[i];
          end
          if (seen != int'(chk_val)) begin
            err_count++;
            $display("[FAIL] %0t: ast[%0d] gave %0d pulses, expected %0d",
                     $time, chk_ch, seen, chk_val);
          end
        end
        default: begin
        end
      endcase

      if (done && !reported) begin
        reported = 1'b1;
        $display("checker summary: %0d checks, %0d errors", checks, err_count);
      end
    end
  end

endmodule

/* syrf_top.sv */
// syrf data-acquisition core top level
// control block plus one adc, filter and alarm chain per channel

`timescale 1ns/1ps

module syrf_top import syrf_bus_pkg::*, syrf_adc_pkg::*; (
  input  logic                 clk_sys,
  input  logic                 reset,
  input  fx_req_t              fx_req,
  output logic [FX_DATA_W-1:0] fx_q,
  output logic [NUM_CH-1:0]    cs_n,
  output logic [NUM_CH-1:0]    sclk,
  input  logic [NUM_CH-1:0]    sdata,
  output logic [NUM_CH-1:0]    ast_ctrl,
  output logic                 irq_n
);

  logic [NUM_CH-1:0]         conv_start;
  logic [NUM_CH-1:0]         busy;
  logic [NUM_CH-1:0]         over;
  logic [SMOOTH_SHIFT_W-1:0] smooth_shift;
  logic [SAMPLE_W-1:0]       thr [NUM_CH];
  sample_t                   ad_sample [NUM_CH];
  sample_t                   sm_sample [NUM_CH];

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  syrf_regs u_regs (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .fx_req       (fx_req),
    .fx_q         (fx_q),
    .conv_start   (conv_start),
    .smooth_shift (smooth_shift),
    .thr          (thr),
    .busy         (busy),
    .ad_sample    (ad_sample),
    .sm_sample    (sm_sample),
    .over         (over),
    .irq_n        (irq_n)
  );

  // ----------------------------------------------------------------------
  // per-channel datapath
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    adc_serial_rx u_adc (
      .clk_sys    (clk_sys),
      .reset      (reset),
      .conv_start (conv_start[i]),
      .cs_n       (cs_n[i]),
      .sclk       (sclk[i]),
      .sdata      (sdata[i]),
      .busy       (busy[i]),
      .ad_sample  (ad_sample[i])
    );

    smooth_filter u_smooth (
      .clk_sys   (clk_sys),
      .reset     (reset),
      .ad_sample (ad_sample[i]),
      .shift     (smooth_shift),
      .sm_sample (sm_sample[i])
    );

    // alarm works on the raw sample
    alarm_hold u_alarm (
      .clk_sys   (clk_sys),
      .reset     (reset),
      .ad_sample (ad_sample[i]),
      .thr       (thr[i]),
      .over      (over[i]),
      .ast       (ast_ctrl[i])
    );
  end

endmodule

/* syrf_regs.sv */
// syrf control block
// owns the register map, conversion triggers, sticky alarm status and irq

`timescale 1ns/1ps

module syrf_regs import syrf_bus_pkg::*, syrf_adc_pkg::*; (
  input  logic                      clk_sys,
  input  logic                      reset,
  input  fx_req_t                   fx_req,
  output logic [FX_DATA_W-1:0]      fx_q,
  output logic [NUM_CH-1:0]         conv_start,
  output logic [SMOOTH_SHIFT_W-1:0] smooth_shift,
  output logic [SAMPLE_W-1:0]       thr [NUM_CH],
  input  logic [NUM_CH-1:0]         busy,
  input  sample_t                   ad_sample [NUM_CH],
  input  sample_t                   sm_sample [NUM_CH],
  input  logic [NUM_CH-1:0]         over,
  output logic                      irq_n
);

  localparam int NIB_W = FX_DATA_W / 2;

  logic [FX_OFS_W-1:0]  w_ofs;
  logic [FX_OFS_W-1:0]  r_ofs;
  logic                 wr_hit;
  logic                 rd_hit;
  logic [NUM_CH-1:0]    ctrl_en;
  logic [NUM_CH-1:0]    irq_mask;
  logic [NUM_CH-1:0]    alarm;
  logic [NUM_CH-1:0]    alarm_clr;
  logic [SAMPLE_W-1:0]  sample_reg [NUM_CH];
  logic [SAMPLE_W-1:0]  smooth_reg [NUM_CH];
  logic [FX_DATA_W-1:0] rd_byte;

  // offset of a per-channel register
  function automatic logic [FX_OFS_W-1:0] ch_ofs(input fx_reg_e base, input int ch);
    return base + FX_OFS_W'(CH_STRIDE * ch);
  endfunction

  // ----------------------------------------------------------------------
  // bus decode
  // ----------------------------------------------------------------------
  assign w_ofs  = fx_req.waddr[FX_OFS_W-1:0];
  assign r_ofs  = fx_req.raddr[FX_OFS_W-1:0];
  assign wr_hit = fx_req.wr && (fx_req.waddr[FX_ADDR_W-1 -: FX_DEV_W] == CTRL_DEV_ID);
  assign rd_hit = fx_req.rd && (fx_req.raddr[FX_ADDR_W-1 -: FX_DEV_W] == CTRL_DEV_ID);

  // triggers go out in the write cycle, only to idle enabled channels
  assign conv_start = (wr_hit && w_ofs == REG_START) ?
                      (fx_req.data[NUM_CH-1:0] & ctrl_en & ~busy) : '0;

  // write 1 to clear
  assign alarm_clr = (wr_hit && w_ofs == REG_STATUS) ? fx_req.data[NUM_CH-1:0] : '0;

  // ----------------------------------------------------------------------
  // register file and status
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      ctrl_en      <= '0;
      irq_mask     <= '0;
      smooth_shift <= '0;
      alarm        <= '0;
      irq_n        <= 1'b1;
      for (int i = 0; i < NUM_CH; i++) begin
        thr[i]        <= '0;
        sample_reg[i] <= '0;
        smooth_reg[i] <= '0;
      end
    end else begin
      if (wr_hit && w_ofs == REG_CTRL)     ctrl_en      <= fx_req.data[NUM_CH-1:0];
      if (wr_hit && w_ofs == REG_IRQ_MASK) irq_mask     <= fx_req.data[NUM_CH-1:0];
      if (wr_hit && w_ofs == REG_SMOOTH)   smooth_shift <= fx_req.data[SMOOTH_SHIFT_W-1:0];

      // a new alarm wins over a clear in the same cycle
      alarm <= (alarm & ~alarm_clr) | over;
      irq_n <= ~|(alarm & irq_mask);

      for (int i = 0; i < NUM_CH; i++) begin
        if (wr_hit && w_ofs == ch_ofs(REG_THR_LO, i))
          thr[i][FX_DATA_W-1:0] <= fx_req.data;
        if (wr_hit && w_ofs == ch_ofs(REG_THR_HI, i))
          thr[i][SAMPLE_W-1:FX_DATA_W] <= fx_req.data;
        if (ad_sample[i].valid)
          sample_reg[i] <= ad_sample[i].data;
        if (sm_sample[i].valid)
          smooth_reg[i] <= sm_sample[i].data;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read-back
  // ----------------------------------------------------------------------
  always_comb begin
    rd_byte = '0;
    if (rd_hit) begin
      case (r_ofs)
        REG_CTRL:     rd_byte = FX_DATA_W'(ctrl_en);
        REG_SMOOTH:   rd_byte = FX_DATA_W'(smooth_shift);
        REG_IRQ_MASK: rd_byte = FX_DATA_W'(irq_mask);
        // busy in the high nibble, sticky alarms in the low one
        REG_STATUS:   rd_byte = {NIB_W'(busy), NIB_W'(alarm)};
        default:      rd_byte = '0;
      endcase
      for (int i = 0; i < NUM_CH; i++) begin
        if (r_ofs == ch_ofs(REG_THR_LO, i))    rd_byte = thr[i][FX_DATA_W-1:0];
        if (r_ofs == ch_ofs(REG_THR_HI, i))    rd_byte = thr[i][SAMPLE_W-1:FX_DATA_W];
        if (r_ofs == ch_ofs(REG_SAMPLE_LO, i)) rd_byte = sample_reg[i][FX_DATA_W-1:0];
        if (r_ofs == ch_ofs(REG_SAMPLE_HI, i)) rd_byte = sample_reg[i][SAMPLE_W-1:FX_DATA_W];
        if (r_ofs == ch_ofs(REG_SMOOTH_LO, i)) rd_byte = smooth_reg[i][FX_DATA_W-1:0];
        if (r_ofs == ch_ofs(REG_SMOOTH_HI, i)) rd_byte = smooth_reg[i][SAMPLE_W-1:FX_DATA_W];
      end
    end
  end

  // read data holds until the next strobe
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      fx_q <= '0;
    end else if (fx_req.rd) begin
      fx_q <= rd_byte;
    end
  end

endmodule

/* alarm_hold.sv */
// threshold alarm with retriggerable hold
// ast stays high for AST_HOLD cycles after the last sample above thr

`timescale 1ns/1ps

module alarm_hold import syrf_adc_pkg::*; (
  input  logic                clk_sys,
  input  logic                reset,
  input  sample_t             ad_sample,
  input  logic [SAMPLE_W-1:0] thr,
  output logic                over,
  output logic                ast
);

  localparam int HOLD_W = $clog2(AST_HOLD);

  logic              hit;
  logic [HOLD_W-1:0] hold_cnt;

  // strictly greater, equal is no alarm
  assign hit = ad_sample.valid && (ad_sample.data > thr);

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      over     <= 1'b0;
      ast      <= 1'b0;
      hold_cnt <= '0;
    end else begin
      over <= hit;
      if (hit) begin
        ast      <= 1'b1;
        hold_cnt <= HOLD_W'(AST_HOLD - 1);
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end else begin
        ast <= 1'b0;
      end
    end
  end

endmodule

/* smooth_filter.sv */
// exponential smoothing filter
// moves the output toward each new sample by (sample - old) >>> k

`timescale 1ns/1ps

module smooth_filter import syrf_adc_pkg::*; (
  input  logic                      clk_sys,
  input  logic                      reset,
  input  sample_t                   ad_sample,
  input  logic [SMOOTH_SHIFT_W-1:0] shift,
  output sample_t                   sm_sample
);

  logic [SAMPLE_W-1:0]        acc;
  logic                       valid;
  logic signed [SAMPLE_W:0]   diff;
  logic signed [SAMPLE_W:0]   step;

  // one extra bit keeps the difference signed
  assign diff = $signed({1'b0, ad_sample.data}) - $signed({1'b0, acc});
  assign step = diff >>> shift;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      acc   <= '0;
      valid <= 1'b0;
    end else begin
      valid <= ad_sample.valid;
      if (ad_sample.valid) begin
        acc <= acc + step[SAMPLE_W-1:0];
      end
    end
  end

  assign sm_sample = '{data: acc, valid: valid};

endmodule

/* adc_serial_rx.sv */
// serial adc reader
// drives cs_n and sclk, shifts in one msb-first sample per trigger

`timescale 1ns/1ps

module adc_serial_rx import syrf_adc_pkg::*; (
  input  logic    clk_sys,
  input  logic    reset,
  input  logic    conv_start,
  output logic    cs_n,
  output logic    sclk,
  input  logic    sdata,
  output logic    busy,
  output sample_t ad_sample
);

  localparam int PH_W  = $clog2(2 * SCLK_HALF);
  localparam int CNT_W = $clog2(SAMPLE_W + 1);

  adc_state_e          state;
  logic [PH_W-1:0]     ph;
  logic [CNT_W-1:0]    bit_cnt;
  logic [SAMPLE_W-1:0] shreg;
  logic                valid;
  logic                all_bits;
  logic                sclk_fall;
  logic                sclk_rise;

  assign all_bits  = (bit_cnt == CNT_W'(SAMPLE_W));
  // sclk falls at phase 0 and rises half a period later
  assign sclk_fall = (state == ADC_SHIFT) && !all_bits && (ph == '0);
  assign sclk_rise = (state == ADC_SHIFT) && !all_bits && (ph == PH_W'(SCLK_HALF));

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state   <= ADC_IDLE;
      cs_n    <= 1'b1;
      sclk    <= 1'b1;
      ph      <= '0;
      bit_cnt <= '0;
      valid   <= 1'b0;
    end else begin
      valid <= 1'b0;
      case (state)
        ADC_IDLE: begin
          if (conv_start) begin
            state   <= ADC_SHIFT;
            cs_n    <= 1'b0;
            ph      <= '0;
            bit_cnt <= '0;
          end
        end
        ADC_SHIFT: begin
          ph <= (ph == PH_W'(2 * SCLK_HALF - 1)) ? '0 : ph + 1'b1;
          if (all_bits) begin
            // release cs one cycle after the last rising edge
            state <= ADC_DONE;
            cs_n  <= 1'b1;
          end else if (sclk_fall) begin
            sclk <= 1'b0;
          end else if (sclk_rise) begin
            sclk    <= 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ADC_DONE: begin
          valid <= 1'b1;
          state <= ADC_IDLE;
        end
        default: state <= ADC_IDLE;
      endcase
    end
  end

  // sample sdata on each rising sclk edge
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      shreg <= '0;
    end else if (sclk_rise) begin
      shreg <= {shreg[SAMPLE_W-2:0], sdata};
    end
  end

  assign busy      = (state != ADC_IDLE);
  assign ad_sample = '{data: shreg, valid: valid};

endmodule

/* syrf_adc_pkg.sv */
// adc datapath package for the syrf core
// channel count, sample format, serial timing and alarm hold constants

package syrf_adc_pkg;

  // ----------------------------------------------------------------------
  // channel and sample format
  // ----------------------------------------------------------------------
  localparam int NUM_CH   = 2;
  localparam int SAMPLE_W = 16;

  // clk_sys cycles per half sclk period
  localparam int SCLK_HALF = 2;

  // ast high time in clk_sys cycles
  localparam int AST_HOLD = 32;

  // smoothing shift k, 0 to 3
  localparam int SMOOTH_SHIFT_W = 2;

  // one sample word with its strobe
  typedef struct packed {
    logic [SAMPLE_W-1:0] data;
    logic                valid;
  } sample_t;

  // serial reader FSM
  typedef enum logic [1:0] {
    ADC_IDLE,
    ADC_SHIFT,
    ADC_DONE
  } adc_state_e;

endpackage

/* syrf_bus_pkg.sv */
// register bus package for the syrf data-acquisition core
// fx bus widths, request struct, control device id and register map

package syrf_bus_pkg;

  // ----------------------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------------------
  localparam int FX_ADDR_W = 22;
  localparam int FX_DATA_W = 8;
  localparam int FX_DEV_W  = 6;
  localparam int FX_OFS_W  = FX_ADDR_W - FX_DEV_W;

  // device id answered by the control module
  localparam logic [FX_DEV_W-1:0] CTRL_DEV_ID = 6'h01;

  // spacing of the per-channel register blocks
  localparam int CH_STRIDE = 16;

  // write and read sides share one request word
  typedef struct packed {
    logic                 wr;
    logic [FX_ADDR_W-1:0] waddr;
    logic [FX_DATA_W-1:0] data;
    logic                 rd;
    logic [FX_ADDR_W-1:0] raddr;
  } fx_req_t;

  // ----------------------------------------------------------------------
  // register offsets
  // ----------------------------------------------------------------------
  // per-channel entries are the channel 0 offsets, add CH_STRIDE per channel
  typedef enum logic [FX_OFS_W-1:0] {
    REG_CTRL      = 16'h0000,
    REG_START     = 16'h0001,
    REG_SMOOTH    = 16'h0002,
    REG_IRQ_MASK  = 16'h0003,
    REG_STATUS    = 16'h0004,
    REG_THR_LO    = 16'h0010,
    REG_THR_HI    = 16'h0011,
    REG_SAMPLE_LO = 16'h0012,
    REG_SAMPLE_HI = 16'h0013,
    REG_SMOOTH_LO = 16'h0014,
    REG_SMOOTH_HI = 16'h0015
  } fx_reg_e;

endpackage
